// File: Makefile
VERILATOR = verilator
FLAGS = --binary --timing --assert -Wno-fatal
TOP = tbRasterizer
FILELIST = src.f
BUILD_DIR = obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qF '** PASS **'

clean:
	rm -rf $(BUILD_DIR)

// File: edgeStepper.sv
// Position and edge-function registers; x wraps at 11 bits when stepping past the box edge
`timescale 1ns/100ps
`default_nettype none

module edgeStepper
(
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic                                  load,
    input  logic [rasterPkg::attributeSize-1:0]   startW0,
    input  logic [rasterPkg::attributeSize-1:0]   startW1,
    input  logic [rasterPkg::attributeSize-1:0]   startW2,
    input  logic [rasterPkg::xBitWidth-1:0]       startX,
    input  logic [rasterPkg::yBitWidth-1:0]       startYScreen,
    input  logic [rasterPkg::yBitWidth-1:0]       startY,
    input  logic [rasterPkg::attributeSize-1:0]   bbStart,
    input  logic [rasterPkg::attributeSize-1:0]   bbEnd,
    input  logic [rasterPkg::attributeSize-1:0]   w0IncX,
    input  logic [rasterPkg::attributeSize-1:0]   w1IncX,
    input  logic [rasterPkg::attributeSize-1:0]   w2IncX,
    input  logic [rasterPkg::attributeSize-1:0]   w0IncY,
    input  logic [rasterPkg::attributeSize-1:0]   w1IncY,
    input  logic [rasterPkg::attributeSize-1:0]   w2IncY,
    input  logic [rasterPkg::yBitWidth-1:0]       yScreenEnd,
    walkStepIf.stepper                            stepIf
);

    logic [rasterPkg::attributeSize-1:0] regW0;
    logic [rasterPkg::attributeSize-1:0] regW1;
    logic [rasterPkg::attributeSize-1:0] regW2;
    logic [rasterPkg::xBitWidth-1:0]     bbStartX;
    logic [rasterPkg::xBitWidth-1:0]     bbEndX;

    assign bbStartX = bbStart[rasterPkg::bbXPos +: rasterPkg::xBitWidth];
    assign bbEndX = bbEnd[rasterPkg::bbXPos +: rasterPkg::xBitWidth];

    // A pixel is inside when no edge function has gone negative
    assign stepIf.inTriangle = !(regW0[rasterPkg::attributeSize-1]
        || regW1[rasterPkg::attributeSize-1] || regW2[rasterPkg::attributeSize-1]);

    // The box end is exclusive in x
    assign stepIf.inBoundsX = (stepIf.x >= bbStartX) && (stepIf.x < bbEndX);
    assign stepIf.atBbStartX = stepIf.x == bbStartX;
    assign stepIf.atBbEndX = stepIf.x == bbEndX;
    assign stepIf.rowsLeft = stepIf.yScreen < yScreenEnd;

    // Counters
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            stepIf.x <= '0;
            stepIf.y <= '0;
            stepIf.yScreen <= '0;
        end
        else if (load)
        begin
            stepIf.x <= startX;
            stepIf.y <= startY;
            stepIf.yScreen <= startYScreen;
        end
        else if (stepIf.stepLine)
        begin
            // A line step keeps x, the walker turns around from where it stands
            stepIf.y <= stepIf.y + 1'b1;
            stepIf.yScreen <= stepIf.yScreen + 1'b1;
        end
        else if (stepIf.stepPixel)
        begin
            stepIf.x <= stepIf.stepLeft ? stepIf.x - 1'b1 : stepIf.x + 1'b1;
        end
    end

    // Edge function accumulators follow the same steps as the counters
    always_ff @(posedge clk)
    begin
        if (load)
        begin
            regW0 <= startW0;
            regW1 <= startW1;
            regW2 <= startW2;
        end
        else if (stepIf.stepLine)
        begin
            regW0 <= regW0 + w0IncY;
            regW1 <= regW1 + w1IncY;
            regW2 <= regW2 + w2IncY;
        end
        else if (stepIf.stepPixel && stepIf.stepLeft)
        begin
            regW0 <= regW0 - w0IncX;
            regW1 <= regW1 - w1IncX;
            regW2 <= regW2 - w2IncX;
        end
        else if (stepIf.stepPixel)
        begin
            regW0 <= regW0 + w0IncX;
            regW1 <= regW1 + w1IncX;
            regW2 <= regW2 + w2IncX;
        end
    end

endmodule

`default_nettype wire

// File: edgeWalker.sv
// Zig-zag edge walker for convex triangles; a line is given up only after both sides were searched
`timescale 1ns/100ps
`default_nettype none

module edgeWalker
(
    input  logic         clk,
    input  logic         reset,
    input  logic         load,
    input  logic         active,
    input  logic         fragmentReady,
    walkStepIf.walker    stepIf,
    output logic         fragValid,
    output logic         fragLast
);

    rasterPkg::walkState_t state;

    logic direction;
    logic tryOtherSide;
    logic insideBox;
    logic advance;

    assign insideBox = stepIf.inTriangle && stepIf.inBoundsX;

    // Nothing moves while the sink stalls or once the band is finished
    assign advance = active && fragmentReady && stepIf.rowsLeft;
    assign stepIf.stepLeft = direction == rasterPkg::walkDirLeft;

    // Checking the direction costs one idle cycle, which also keeps x from running away
    always_comb
    begin
        stepIf.stepPixel = 1'b0;
        stepIf.stepLine = 1'b0;
        if (advance && (state != rasterPkg::checkWalkingDir))
        begin
            if ((state == rasterPkg::walk) && !insideBox)
            begin
                stepIf.stepLine = 1'b1;
            end
            else
            begin
                stepIf.stepPixel = 1'b1;
            end
        end
    end

    // The current pixel is emitted whenever the walker finds it inside the box and the triangle
    always_comb
    begin
        if (!active)
        begin
            fragValid = 1'b0;
        end
        else if (!stepIf.rowsLeft)
        begin
            fragValid = 1'b1;
        end
        else
        begin
            case (state)
                rasterPkg::walkInit,
                rasterPkg::searchEdge,
                rasterPkg::walk:
                    fragValid = insideBox;
                default:
                    fragValid = 1'b0;
            endcase
        end
    end

    // Below the last line the closing beat goes out
    assign fragLast = active && !stepIf.rowsLeft;

    always_ff @(posedge clk)
    begin
        if (reset || load)
        begin
            state <= rasterPkg::walkInit;
            direction <= rasterPkg::walkDirRight;
            tryOtherSide <= 1'b0;
        end
        else if (advance)
        begin
            case (state)
                rasterPkg::walkInit:
                begin
                    state <= insideBox ? rasterPkg::walk : rasterPkg::searchEdge;
                end
                rasterPkg::checkWalkingDir:
                begin
                    // Still inside after the line step, so first walk out in the old direction
                    if (stepIf.inTriangle)
                    begin
                        state <= rasterPkg::walkOut;
                    end
                    else
                    begin
                        // Usually the triangle now lies on the other side
                        direction <= !direction;
                        state <= rasterPkg::searchEdge;
                    end
                end
                rasterPkg::searchEdge:
                begin
                    if (insideBox)
                    begin
                        tryOtherSide <= 1'b0;
                        state <= rasterPkg::walk;
                    end
                    else if (stepIf.atBbEndX)
                    begin
                        // Near a vertex the triangle can sit on the unexpected side
                        if ((direction == rasterPkg::walkDirRight) && tryOtherSide)
                        begin
                            tryOtherSide <= 1'b0;
                            state <= rasterPkg::walk;
                        end
                        else
                        begin
                            tryOtherSide <= 1'b1;
                            direction <= rasterPkg::walkDirLeft;
                        end
                    end
                    else if (stepIf.atBbStartX)
                    begin
                        if ((direction == rasterPkg::walkDirLeft) && tryOtherSide)
                        begin
                            tryOtherSide <= 1'b0;
                            state <= rasterPkg::walk;
                        end
                        else
                        begin
                            tryOtherSide <= 1'b1;
                            direction <= rasterPkg::walkDirRight;
                        end
                    end
                end
                rasterPkg::walkOut:
                begin
                    if (!stepIf.inTriangle || stepIf.atBbStartX || stepIf.atBbEndX)
                    begin
                        direction <= !direction;
                        state <= rasterPkg::searchEdge;
                    end
                end
                rasterPkg::walk:
                begin
                    if (!insideBox)
                    begin
                        state <= rasterPkg::checkWalkingDir;
                    end
                end
                default:
                begin
                    state <= rasterPkg::walkInit;
                end
            endcase
        end
    end

    // A line step comes alone and two lines are never stepped back to back
    assert property (@(posedge clk) disable iff (reset)
        stepIf.stepLine |-> !stepIf.stepPixel ##1 !stepIf.stepLine);

endmodule

`default_nettype wire

// File: fragmentOutput.sv
// Fragment register stage; the index counts rows from the band bottom and is truncated to 14 bits
`timescale 1ns/100ps
`default_nettype none

module fragmentOutput
(
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               fragmentReady,
    input  logic                               fragValid,
    input  logic                               fragLast,
    input  logic [rasterPkg::xBitWidth-1:0]    x,
    input  logic [rasterPkg::yBitWidth-1:0]    y,
    input  logic [rasterPkg::yBitWidth-1:0]    yScreen,
    input  logic [rasterPkg::xBitWidth-1:0]    xResolution,
    input  logic [rasterPkg::yBitWidth-1:0]    yResolution,
    output logic                               fragmentValid,
    output logic                               fragmentLast,
    output logic [rasterPkg::xBitWidth-1:0]    fragmentX,
    output logic [rasterPkg::yBitWidth-1:0]    fragmentY,
    output logic [rasterPkg::indexWidth-1:0]   fragmentIndex
);

    logic [rasterPkg::yBitWidth-1:0]                      rowFromBottom;
    logic [rasterPkg::xBitWidth+rasterPkg::yBitWidth-1:0] linearIndex;
    logic                                                 inResolution;

    // The framebuffer is stored bottom up
    assign rowFromBottom = yResolution - 1'b1 - y;
    assign linearIndex = rowFromBottom * xResolution + x;
    assign inResolution = (y < yResolution) && (x < xResolution);

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            fragmentValid <= 1'b0;
            fragmentLast <= 1'b0;
        end
        else if (fragmentReady)
        begin
            fragmentValid <= fragValid;
            fragmentLast <= fragLast;
        end
    end

    always_ff @(posedge clk)
    begin
        if (fragmentReady)
        begin
            fragmentX <= x;
            fragmentY <= yScreen;
            // Outside the viewport the last index is kept so it never points past the buffer
            if (inResolution)
            begin
                fragmentIndex <= linearIndex[rasterPkg::indexWidth-1:0];
            end
        end
    end

    // The walker only closes a triangle with a valid beat
    assert property (@(posedge clk) disable iff (reset) fragmentLast |-> fragmentValid);

endmodule

`default_nettype wire

// File: rasterPkg.sv
// Shared widths and encodings; screen coordinates are limited to 11 bits and weights to 32 bits
`default_nettype none

package rasterPkg;

    // Screen coordinate widths, enough for a 2048 x 2048 screen
    localparam int xBitWidth = 11;
    localparam int yBitWidth = 11;

    // Framebuffer index width, which bounds the size of one rendered band
    localparam int indexWidth = 14;

    // Width of a weight, an increment and a packed bounding-box word
    localparam int attributeSize = 32;

    // The bounding-box word carries x in the low half and y in the high half
    localparam int bbXPos = 0;
    localparam int bbYPos = 16;

    // Edge walker states
    typedef enum logic [2:0]
    {
        walkInit,
        searchEdge,
        walkOut,
        walk,
        checkWalkingDir
    } walkState_t;

    // Walking direction codes
    localparam logic walkDirRight = 1'b1;
    localparam logic walkDirLeft = 1'b0;

    // Main control states
    typedef enum logic [1:0]
    {
        waitForCommand,
        init,
        test
    } mainState_t;

endpackage

`default_nettype wire

// File: rasterSetup.sv
// Main control; start is ignored while running, and band sums wrap at 11 bits without saturation
`timescale 1ns/100ps
`default_nettype none

module rasterSetup
(
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic                                  start,
    input  logic [rasterPkg::yBitWidth-1:0]       yOffset,
    input  logic [rasterPkg::yBitWidth-1:0]       yResolution,
    input  logic [rasterPkg::attributeSize-1:0]   bbStart,
    input  logic [rasterPkg::attributeSize-1:0]   bbEnd,
    input  logic [rasterPkg::attributeSize-1:0]   w0,
    input  logic [rasterPkg::attributeSize-1:0]   w1,
    input  logic [rasterPkg::attributeSize-1:0]   w2,
    input  logic [rasterPkg::attributeSize-1:0]   w0IncY,
    input  logic [rasterPkg::attributeSize-1:0]   w1IncY,
    input  logic [rasterPkg::attributeSize-1:0]   w2IncY,
    input  logic                                  fragmentReady,
    input  logic                                  fragLast,
    output logic                                  running,
    output logic                                  load,
    output logic                                  active,
    output logic [rasterPkg::attributeSize-1:0]   startW0,
    output logic [rasterPkg::attributeSize-1:0]   startW1,
    output logic [rasterPkg::attributeSize-1:0]   startW2,
    output logic [rasterPkg::xBitWidth-1:0]       startX,
    output logic [rasterPkg::yBitWidth-1:0]       startYScreen,
    output logic [rasterPkg::yBitWidth-1:0]       startY,
    output logic [rasterPkg::yBitWidth-1:0]       yScreenEnd
);

    rasterPkg::mainState_t state;

    logic [rasterPkg::yBitWidth-1:0] bbStartY;
    logic [rasterPkg::yBitWidth-1:0] bbEndY;
    logic [rasterPkg::yBitWidth-1:0] bandEnd;
    logic [rasterPkg::yBitWidth-1:0] lineBbStart;
    logic                            boxAboveBand;

    // Moves a weight down by a number of lines; only the low 32 bits of the product matter
    function automatic logic [rasterPkg::attributeSize-1:0] advanceWeight
    (
        input logic [rasterPkg::attributeSize-1:0] w,
        input logic [rasterPkg::attributeSize-1:0] incY,
        input logic [rasterPkg::yBitWidth-1:0]     lines
    );
        return w + ($signed(incY) * $signed({1'b0, lines}));
    endfunction

    assign bbStartY = bbStart[rasterPkg::bbYPos +: rasterPkg::yBitWidth];
    assign bbEndY = bbEnd[rasterPkg::bbYPos +: rasterPkg::yBitWidth];
    assign bandEnd = yOffset + yResolution;

    // The box starts on a line above the band, so the skipped lines are folded into the weights
    assign boxAboveBand = yOffset > bbStartY;

    assign startW0 = boxAboveBand ? advanceWeight(w0, w0IncY, lineBbStart) : w0;
    assign startW1 = boxAboveBand ? advanceWeight(w1, w1IncY, lineBbStart) : w1;
    assign startW2 = boxAboveBand ? advanceWeight(w2, w2IncY, lineBbStart) : w2;
    assign startX = bbStart[rasterPkg::bbXPos +: rasterPkg::xBitWidth];

    // yScreen is the absolute line while y counts lines inside the band
    assign startYScreen = boxAboveBand ? yOffset : bbStartY;
    assign startY = boxAboveBand ? '0 : bbStartY - yOffset;

    assign load = state == rasterPkg::init;
    assign active = state == rasterPkg::test;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state <= rasterPkg::waitForCommand;
            running <= 1'b0;
        end
        else
        begin
            case (state)
                rasterPkg::waitForCommand:
                begin
                    // Running stays up until the pending closing beat leaves the output
                    if (running && fragmentReady)
                    begin
                        running <= 1'b0;
                    end
                    else if (!running && start)
                    begin
                        running <= 1'b1;
                        state <= rasterPkg::init;
                    end
                end
                rasterPkg::init:
                begin
                    state <= rasterPkg::test;
                end
                rasterPkg::test:
                begin
                    // The closing beat enters the output register on this edge
                    if (fragLast && fragmentReady)
                    begin
                        state <= rasterPkg::waitForCommand;
                    end
                end
                default:
                begin
                    state <= rasterPkg::waitForCommand;
                end
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if ((state == rasterPkg::waitForCommand) && !running && start)
        begin
            lineBbStart <= yOffset - bbStartY;
        end
        // Clamp the end line to whichever comes first, the band end or the box end
        // An end above the start line makes the walker close at once
        if (load)
        begin
            yScreenEnd <= (bandEnd <= bbEndY) ? bandEnd : bbEndY;
        end
    end

    // A load only follows a start that arrived while the rasterizer was idle
    assert property (@(posedge clk) disable iff (reset)
        load |-> $past(start) && !$past(running));

endmodule

`default_nettype wire

// File: rasterizer.sv
// Rasterizer top; one triangle per start pulse, inputs must stay stable while running is high
`timescale 1ns/100ps
`default_nettype none

module rasterizer
(
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic                                  start,
    input  logic [rasterPkg::yBitWidth-1:0]       yOffset,
    input  logic [rasterPkg::xBitWidth-1:0]       xResolution,
    input  logic [rasterPkg::yBitWidth-1:0]       yResolution,
    input  logic [rasterPkg::attributeSize-1:0]   bbStart,
    input  logic [rasterPkg::attributeSize-1:0]   bbEnd,
    input  logic [rasterPkg::attributeSize-1:0]   w0,
    input  logic [rasterPkg::attributeSize-1:0]   w1,
    input  logic [rasterPkg::attributeSize-1:0]   w2,
    input  logic [rasterPkg::attributeSize-1:0]   w0IncX,
    input  logic [rasterPkg::attributeSize-1:0]   w1IncX,
    input  logic [rasterPkg::attributeSize-1:0]   w2IncX,
    input  logic [rasterPkg::attributeSize-1:0]   w0IncY,
    input  logic [rasterPkg::attributeSize-1:0]   w1IncY,
    input  logic [rasterPkg::attributeSize-1:0]   w2IncY,
    input  logic                                  fragmentReady,
    output logic                                  running,
    output logic                                  fragmentValid,
    output logic                                  fragmentLast,
    output logic [rasterPkg::xBitWidth-1:0]       fragmentX,
    output logic [rasterPkg::yBitWidth-1:0]       fragmentY,
    output logic [rasterPkg::indexWidth-1:0]      fragmentIndex
);

    logic                                load;
    logic                                active;
    logic                                fragValid;
    logic                                fragLast;
    logic [rasterPkg::attributeSize-1:0] startW0;
    logic [rasterPkg::attributeSize-1:0] startW1;
    logic [rasterPkg::attributeSize-1:0] startW2;
    logic [rasterPkg::xBitWidth-1:0]     startX;
    logic [rasterPkg::yBitWidth-1:0]     startYScreen;
    logic [rasterPkg::yBitWidth-1:0]     startY;
    logic [rasterPkg::yBitWidth-1:0]     yScreenEnd;

    walkStepIf stepIf ();

    // Control and band clipping
    rasterSetup setup
    (
        .clk(clk), .reset(reset), .start(start),
        .yOffset(yOffset), .yResolution(yResolution),
        .bbStart(bbStart), .bbEnd(bbEnd),
        .w0(w0), .w1(w1), .w2(w2),
        .w0IncY(w0IncY), .w1IncY(w1IncY), .w2IncY(w2IncY),
        .fragmentReady(fragmentReady), .fragLast(fragLast),
        .running(running), .load(load), .active(active),
        .startW0(startW0), .startW1(startW1), .startW2(startW2),
        .startX(startX), .startYScreen(startYScreen), .startY(startY),
        .yScreenEnd(yScreenEnd)
    );

    edgeStepper stepper
    (
        .clk(clk), .reset(reset), .load(load),
        .startW0(startW0), .startW1(startW1), .startW2(startW2),
        .startX(startX), .startYScreen(startYScreen), .startY(startY),
        .bbStart(bbStart), .bbEnd(bbEnd),
        .w0IncX(w0IncX), .w1IncX(w1IncX), .w2IncX(w2IncX),
        .w0IncY(w0IncY), .w1IncY(w1IncY), .w2IncY(w2IncY),
        .yScreenEnd(yScreenEnd), .stepIf(stepIf.stepper)
    );

    edgeWalker walker
    (
        .clk(clk), .reset(reset), .load(load), .active(active),
        .fragmentReady(fragmentReady), .stepIf(stepIf.walker),
        .fragValid(fragValid), .fragLast(fragLast)
    );

    // The position reaches the output stage straight from the stepper registers
    fragmentOutput outStage
    (
        .clk(clk), .reset(reset), .fragmentReady(fragmentReady),
        .fragValid(fragValid), .fragLast(fragLast),
        .x(stepIf.x), .y(stepIf.y), .yScreen(stepIf.yScreen),
        .xResolution(xResolution), .yResolution(yResolution),
        .fragmentValid(fragmentValid), .fragmentLast(fragmentLast),
        .fragmentX(fragmentX), .fragmentY(fragmentY), .fragmentIndex(fragmentIndex)
    );

endmodule

`default_nettype wire

// File: src.f
rasterPkg.sv
walkStepIf.sv
rasterSetup.sv
edgeStepper.sv
edgeWalker.sv
fragmentOutput.sv
rasterizer.sv
tbRasterizer.sv

// File: tbRasterizer.sv
// Directed testbench for one fixed triangle; coverage is checked on a 64 x 64 pixel screen area only
`timescale 1ns/100ps
`default_nettype none

module tbRasterizer;

    // The box of the test triangle has exclusive ends in x and y
    localparam int boxX0 = 2;
    localparam int boxY0 = 1;
    localparam int boxX1 = 31;
    localparam int boxY1 = 26;
    localparam int boxArea = (boxX1 - boxX0) * (boxY1 - boxY0);
    localparam int numTests = 5;
    localparam int screenSize = 64;

    logic                                  clk;
    logic                                  reset;
    logic                                  start;
    logic [rasterPkg::yBitWidth-1:0]       yOffset;
    logic [rasterPkg::xBitWidth-1:0]       xResolution;
    logic [rasterPkg::yBitWidth-1:0]       yResolution;
    logic [rasterPkg::attributeSize-1:0]   bbStart;
    logic [rasterPkg::attributeSize-1:0]   bbEnd;
    logic [rasterPkg::attributeSize-1:0]   w0;
    logic [rasterPkg::attributeSize-1:0]   w1;
    logic [rasterPkg::attributeSize-1:0]   w2;
    logic [rasterPkg::attributeSize-1:0]   w0IncX;
    logic [rasterPkg::attributeSize-1:0]   w1IncX;
    logic [rasterPkg::attributeSize-1:0]   w2IncX;
    logic [rasterPkg::attributeSize-1:0]   w0IncY;
    logic [rasterPkg::attributeSize-1:0]   w1IncY;
    logic [rasterPkg::attributeSize-1:0]   w2IncY;
    logic                                  fragmentReady;
    logic                                  running;
    logic                                  fragmentValid;
    logic                                  fragmentLast;
    logic [rasterPkg::xBitWidth-1:0]       fragmentX;
    logic [rasterPkg::yBitWidth-1:0]       fragmentY;
    logic [rasterPkg::indexWidth-1:0]      fragmentIndex;

    // Band and screen setup as plain numbers for the reference model
    int bandOffset;
    int bandLines;
    int screenWidth;
    integer seed;

    // One flag per pixel that has been received in the current triangle
    bit seen [screenSize][screenSize];

    rasterizer UUT
    (
        .clk(clk), .reset(reset), .start(start),
        .yOffset(yOffset), .xResolution(xResolution), .yResolution(yResolution),
        .bbStart(bbStart), .bbEnd(bbEnd),
        .w0(w0), .w1(w1), .w2(w2),
        .w0IncX(w0IncX), .w1IncX(w1IncX), .w2IncX(w2IncX),
        .w0IncY(w0IncY), .w1IncY(w1IncY), .w2IncY(w2IncY),
        .fragmentReady(fragmentReady), .running(running),
        .fragmentValid(fragmentValid), .fragmentLast(fragmentLast),
        .fragmentX(fragmentX), .fragmentY(fragmentY), .fragmentIndex(fragmentIndex)
    );

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic reportFailure();
        $display("** FAIL **");
        $fatal(1, "Stopping at the first error");
    endtask

    // Edge function a*x + b*y + c taken at the box start corner
    function automatic int cornerWeight(input int a, input int b, input int c);
        return a * boxX0 + b * boxY0 + c;
    endfunction

    // Vertices (2,1), (30,5) and (10,25) with every edge function positive inside
    task automatic loadTriangle();
        w0IncX = -4;
        w0IncY = 28;
        w0 = cornerWeight(-4, 28, -20);
        w1IncX = -20;
        w1IncY = -20;
        w1 = cornerWeight(-20, -20, 700);
        w2IncX = 24;
        w2IncY = -8;
        w2 = cornerWeight(24, -8, -40);
        bbStart = (boxY0 << rasterPkg::bbYPos) | (boxX0 << rasterPkg::bbXPos);
        bbEnd = (boxY1 << rasterPkg::bbYPos) | (boxX1 << rasterPkg::bbXPos);
    endtask

    task automatic setBand(input int offset, input int lines);
        bandOffset = offset;
        bandLines = lines;
        screenWidth = screenSize;
        yOffset = offset;
        yResolution = lines;
        xResolution = screenSize;
    endtask

    // A pixel is covered inside the box and the band when no edge function is negative
    function automatic bit covered(input int x, input int y);
        int top;
        int bottom;
        int e0;
        int e1;
        int e2;
        top = (bandOffset > boxY0) ? bandOffset : boxY0;
        bottom = (bandOffset + bandLines < boxY1) ? bandOffset + bandLines : boxY1;
        if ((x < boxX0) || (x >= boxX1) || (y < top) || (y >= bottom))
        begin
            return 1'b0;
        end
        e0 = $signed(w0) + $signed(w0IncX) * (x - boxX0) + $signed(w0IncY) * (y - boxY0);
        e1 = $signed(w1) + $signed(w1IncX) * (x - boxX0) + $signed(w1IncY) * (y - boxY0);
        e2 = $signed(w2) + $signed(w2IncX) * (x - boxX0) + $signed(w2IncY) * (y - boxY0);
        return (e0 >= 0) && (e1 >= 0) && (e2 >= 0);
    endfunction

    // The framebuffer row is counted up from the bottom line of the band
    function automatic logic [rasterPkg::indexWidth-1:0] expectedIndex(input int x, input int y);
        int index;
        index = (bandLines - 1 - (y - bandOffset)) * screenWidth + x;
        return index[rasterPkg::indexWidth-1:0];
    endfunction

    task automatic clearSeen();
        for (int x = 0; x < screenSize; x++)
        begin
            for (int y = 0; y < screenSize; y++)
            begin
                seen[x][y] = 1'b0;
            end
        end
    endtask

    task automatic applyReset();
        reset = 1'b1;
        repeat (2) @(negedge clk);
        reset = 1'b0;
    endtask

    // Called for a pixel beat that transfers on the coming rising edge
    task automatic recordBeat();
        int fx;
        int fy;
        logic [rasterPkg::indexWidth-1:0] wantIndex;
        fx = int'(fragmentX);
        fy = int'(fragmentY);
        assert ((fx < screenSize) && (fy < screenSize)) else
        begin
            $display("A fragment at x %0d y %0d lies outside the checked screen area", fx, fy);
            reportFailure();
        end
        assert (!seen[fx][fy]) else
        begin
            $display("The pixel at x %0d y %0d was emitted more than once", fx, fy);
            reportFailure();
        end
        seen[fx][fy] = 1'b1;
        wantIndex = expectedIndex(fx, fy);
        assert (fragmentIndex == wantIndex) else
        begin
            $display("FAILED fragmentIndex: got %h, expected %h", fragmentIndex, wantIndex);
            reportFailure();
        end
    endtask

    // Every pixel of the screen area must be received exactly when the model covers it
    task automatic compareCoverage();
        for (int y = 0; y < screenSize; y++)
        begin
            for (int x = 0; x < screenSize; x++)
            begin
                assert (seen[x][y] == covered(x, y)) else
                begin
                    $display("FAILED pixel coverage at x %h y %h: got %h, expected %h",
                        x, y, seen[x][y], covered(x, y));
                    reportFailure();
                end
            end
        end
    endtask

    // Starts one triangle and collects beats until the closing beat has transferred
    task automatic renderTriangle(input bit randomReady);
        int cycles;
        int randomWord;
        bit done;
        clearSeen();
        @(negedge clk);
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        assert (running) else
        begin
            $display("FAILED running: got %h, expected %h", running, 1'b1);
            reportFailure();
        end
        cycles = 1;
        done = 1'b0;
        while (!done)
        begin
            if (randomReady)
            begin
                randomWord = $random(seed);
                fragmentReady = randomWord[0];
            end
            if (fragmentValid)
            begin
                assert (cycles >= 3) else
                begin
                    $display("A beat appeared only %0d cycles after start", cycles);
                    reportFailure();
                end
                // The closing beat carries no pixel
                if (fragmentReady && fragmentLast)
                begin
                    done = 1'b1;
                end
                else if (fragmentReady)
                begin
                    recordBeat();
                end
            end
            if (!done)
            begin
                @(negedge clk);
                cycles++;
            end
        end
        fragmentReady = 1'b1;
        @(negedge clk);
        assert (!running) else
        begin
            $display("FAILED running: got %h, expected %h", running, 1'b0);
            reportFailure();
        end
        compareCoverage();
    endtask

    task automatic checkResetState();
        applyReset();
        assert (!running && !fragmentValid && !fragmentLast) else
        begin
            $display("FAILED outputs after reset: running %h, fragmentValid %h, fragmentLast %h",
                running, fragmentValid, fragmentLast);
            reportFailure();
        end
        setBand(0, 32);
        renderTriangle(1'b0);
    endtask

    task automatic checkFullCoverage();
        setBand(0, 32);
        renderTriangle(1'b0);
    endtask

    // The box starts above the band and ends below it, so rows 8 to 17 remain
    task automatic checkLineClipping();
        setBand(8, 10);
        renderTriangle(1'b0);
    endtask

    task automatic checkEmptyResult();
        setBand(40, 10);
        renderTriangle(1'b0);
    endtask

    task automatic checkBackPressure();
        setBand(0, 32);
        renderTriangle(1'b1);
    endtask

    // Budget of four cycles per box pixel for every test
    initial
    begin
        #(boxArea * 4 * numTests * 10);
        $display("Timeout: the rasterizer did not finish the tests in time");
        $display("** FAIL **");
        $fatal(1, "Watchdog expired");
    end

    initial
    begin
        seed = 32'hc263;
        reset = 1'b1;
        start = 1'b0;
        fragmentReady = 1'b1;
        loadTriangle();
        setBand(0, 32);
        checkResetState();
        checkFullCoverage();
        checkLineClipping();
        checkEmptyResult();
        checkBackPressure();
        $display("** PASS **");
        $finish;
    end

endmodule

`default_nettype wire

// File: walkStepIf.sv
// Step commands and position flags between the edge walker and the edge stepper; no clock inside
`timescale 1ns/100ps
`default_nettype none

interface walkStepIf;

    // Step commands, already qualified by the walker with fragmentReady
    logic stepPixel;
    logic stepLine;
    logic stepLeft;

    // Flags derived from the stepper registers
    logic inTriangle;
    logic inBoundsX;
    logic atBbStartX;
    logic atBbEndX;
    logic rowsLeft;

    // Current position, also read by the fragment stage
    logic [rasterPkg::xBitWidth-1:0] x;
    logic [rasterPkg::yBitWidth-1:0] y;
    logic [rasterPkg::yBitWidth-1:0] yScreen;

    modport walker
    (
        output stepPixel, stepLine, stepLeft,
        input  inTriangle, inBoundsX, atBbStartX, atBbEndX, rowsLeft
    );

    modport stepper
    (
        input  stepPixel, stepLine, stepLeft,
        output inTriangle, inBoundsX, atBbStartX, atBbEndX, rowsLeft, x, y, yScreen
    );

endinterface

`default_nettype wire
